//--- common/s2mm_cfg.svh
`ifndef S2MM_CFG_SVH
`define S2MM_CFG_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Stream and AXI write data
`define S2MM_DATA_W 64

// AXI byte address
`define S2MM_ADDR_W 32

// Packet length in beats
`define S2MM_LEN_W 16

//////////////////////////////////////////////////
// Buffering
//////////////////////////////////////////////////

`define S2MM_DATA_DEPTH 512
`define S2MM_LEN_DEPTH 64

// AXI4 INCR limit, one packet per burst
`define S2MM_MAX_BEATS 256

`endif

//--- common/s2mm_pkg.sv
`default_nettype none

`include "s2mm_cfg.svh"

package s2mm_pkg;

    //////////////////////////////////////////////////
    // Stream side
    //////////////////////////////////////////////////

    // One captured input beat
    typedef struct packed {
        logic [`S2MM_DATA_W-1:0] data;
        logic                    last;
    } stream_beat_t;

    typedef logic [`S2MM_LEN_W-1:0] beat_cnt_t;

    //////////////////////////////////////////////////
    // AXI4 write channels
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [`S2MM_ADDR_W-1:0]              addr;
        logic [$clog2(`S2MM_MAX_BEATS)-1:0]   len;
        logic [2:0]                           size;
        logic [1:0]                           burst;
        logic [3:0]                           cache;
    } aw_req_t;

    typedef struct packed {
        logic [`S2MM_DATA_W-1:0]   data;
        logic [`S2MM_DATA_W/8-1:0] strb;
        logic                      last;
    } w_beat_t;

    typedef logic [1:0] axi_resp_t;

endpackage

`default_nettype wire

//--- src/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 16
) (
    input  wire  M_AXI_ACLK,
    input  wire  M_AXI_ARESETN,
    input  wire  i_wr_en,
    input  T     i_wr_data,
    input  wire  i_rd_en,
    output T     o_rd_data,
    output logic o_empty,
    output logic o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T               mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Writes into a full FIFO and reads from an empty one are dropped
    assign do_wr = i_wr_en && !o_full;
    assign do_rd = i_rd_en && !o_empty;

    assign o_empty   = (count == '0);
    assign o_full    = (count == CNT_W'(DEPTH));
    // Head word is visible without a read strobe
    assign o_rd_data = mem[rd_ptr];

    always_ff @(posedge M_AXI_ACLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN) begin
        if (!M_AXI_ARESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/stream_ingress.sv
`timescale 1ns/1ps
`default_nettype none

`include "s2mm_cfg.svh"

module stream_ingress
    import s2mm_pkg::*;
(
    input  wire                     M_AXI_ACLK,
    input  wire                     M_AXI_ARESETN,
    input  wire                     i_axis_valid,
    input  wire [`S2MM_DATA_W-1:0]  i_axis_data,
    input  wire                     i_axis_last,
    output logic                    o_data_wr_en,
    output stream_beat_t            o_data_wr,
    output logic                    o_len_wr_en,
    output beat_cnt_t               o_len_wr
);

    logic         r_valid;
    stream_beat_t r_beat;
    // Beats of the current packet seen before this one
    beat_cnt_t    r_cnt;

    //////////////////////////////////////////////////
    // Input capture
    //////////////////////////////////////////////////

    always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN) begin
        if (!M_AXI_ARESETN) begin
            r_valid <= 1'b0;
        end else begin
            r_valid <= i_axis_valid;
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        r_beat.data <= i_axis_data;
        r_beat.last <= i_axis_last;
    end

    //////////////////////////////////////////////////
    // Beat counting
    //////////////////////////////////////////////////

    always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN) begin
        if (!M_AXI_ARESETN) begin
            r_cnt <= '0;
        end else if (r_valid) begin
            r_cnt <= r_beat.last ? '0 : r_cnt + 1'b1;
        end
    end

    assign o_data_wr_en = r_valid;
    assign o_data_wr    = r_beat;

    // Length lands together with the last beat
    assign o_len_wr_en = r_valid && r_beat.last;
    assign o_len_wr    = r_cnt + 1'b1;

endmodule

`default_nettype wire

//--- src/buffer_request.sv
`timescale 1ns/1ps
`default_nettype none

`include "s2mm_cfg.svh"

module buffer_request
    import s2mm_pkg::*;
(
    input  wire                     M_AXI_ACLK,
    input  wire                     M_AXI_ARESETN,
    input  wire                     i_len_empty,
    input  beat_cnt_t               i_len_head,
    output logic                    o_len_rd_en,
    output beat_cnt_t               o_mem_req_len,
    output logic                    o_mem_req_valid,
    input  wire                     i_mem_req_ready,
    input  wire [`S2MM_ADDR_W-1:0]  i_mem_ack_addr,
    input  wire                     i_mem_ack_valid,
    output logic                    o_mem_ack_ready,
    output logic                    o_start,
    output logic [`S2MM_ADDR_W-1:0] o_start_addr,
    output beat_cnt_t               o_start_len,
    input  wire                     i_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_ACK,
        ST_BUSY
    } state_t;

    state_t                  state;
    beat_cnt_t               r_len;
    logic [`S2MM_ADDR_W-1:0] r_addr;
    logic                    r_start;
    logic                    req_fire;
    logic                    ack_fire;

    // One pop per packet, only while no burst is outstanding
    assign o_len_rd_en     = (state == ST_IDLE) && !i_len_empty;
    assign o_mem_req_valid = (state == ST_REQ);
    assign o_mem_ack_ready = (state == ST_ACK);
    assign req_fire        = o_mem_req_valid && i_mem_req_ready;
    assign ack_fire        = o_mem_ack_ready && i_mem_ack_valid;

    always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN) begin
        if (!M_AXI_ARESETN) begin
            state   <= ST_IDLE;
            r_start <= 1'b0;
        end else begin
            r_start <= ack_fire;
            case (state)
                ST_IDLE: if (o_len_rd_en) state <= ST_REQ;
                ST_REQ:  if (req_fire)    state <= ST_ACK;
                ST_ACK:  if (ack_fire)    state <= ST_BUSY;
                // Lock held until the write response is back
                ST_BUSY: if (i_done)      state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (o_len_rd_en) begin
            r_len <= i_len_head;
        end
        if (ack_fire) begin
            r_addr <= i_mem_ack_addr;
        end
    end

    assign o_mem_req_len = r_len;
    assign o_start       = r_start;
    assign o_start_addr  = r_addr;
    assign o_start_len   = r_len;

endmodule

`default_nettype wire

//--- axi_burst_writer/axi_burst_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "s2mm_cfg.svh"

module axi_burst_writer
    import s2mm_pkg::*;
(
    input  wire                     M_AXI_ACLK,
    input  wire                     M_AXI_ARESETN,
    input  wire                     i_start,
    input  wire [`S2MM_ADDR_W-1:0]  i_start_addr,
    input  beat_cnt_t               i_start_len,
    input  stream_beat_t            i_data_head,
    output logic                    o_data_rd_en,
    output aw_req_t                 o_axi_aw,
    output logic                    o_axi_awvalid,
    input  wire                     i_axi_awready,
    output w_beat_t                 o_axi_w,
    output logic                    o_axi_wvalid,
    input  wire                     i_axi_wready,
    input  axi_resp_t               i_axi_bresp,
    input  wire                     i_axi_bvalid,
    output logic                    o_axi_bready,
    output logic                    o_done
);

    localparam int         AXLEN_W    = $clog2(`S2MM_MAX_BEATS);
    localparam logic [2:0] AXSIZE     = 3'($clog2(`S2MM_DATA_W / 8));
    localparam logic [1:0] BURST_INCR = 2'b01;
    // Normal non-cacheable, modifiable
    localparam logic [3:0] CACHE_MOD  = 4'b0010;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } state_t;

    state_t             state;
    aw_req_t            r_aw;
    logic [AXLEN_W-1:0] r_beat_cnt;
    beat_cnt_t          len_m1;
    logic               aw_fire;
    logic               w_fire;
    logic               b_fire;
    logic               w_last;

    assign len_m1  = i_start_len - 1'b1;
    assign aw_fire = o_axi_awvalid && i_axi_awready;
    assign w_fire  = o_axi_wvalid && i_axi_wready;
    assign b_fire  = i_axi_bvalid && o_axi_bready;
    assign w_last  = (r_beat_cnt == r_aw.len);

    //////////////////////////////////////////////////
    // Channel FSM
    //////////////////////////////////////////////////

    always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN) begin
        if (!M_AXI_ARESETN) begin
            state      <= ST_IDLE;
            r_beat_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    r_beat_cnt <= '0;
                    if (i_start) begin
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (aw_fire) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (w_fire) begin
                        r_beat_cnt <= r_beat_cnt + 1'b1;
                        if (w_last) begin
                            state <= ST_RESP;
                        end
                    end
                end
                ST_RESP: begin
                    if (b_fire) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Address phase fields, frozen for the whole burst
    always_ff @(posedge M_AXI_ACLK) begin
        if (state == ST_IDLE && i_start) begin
            r_aw.addr  <= i_start_addr;
            r_aw.len   <= len_m1[AXLEN_W-1:0];
            r_aw.size  <= AXSIZE;
            r_aw.burst <= BURST_INCR;
            r_aw.cache <= CACHE_MOD;
        end
    end

    //////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////

    assign o_axi_aw      = r_aw;
    assign o_axi_awvalid = (state == ST_ADDR);

    // Data comes straight from the FIFO head
    assign o_axi_w.data  = i_data_head.data;
    assign o_axi_w.strb  = '1;
    assign o_axi_w.last  = w_last;
    assign o_axi_wvalid  = (state == ST_DATA);
    assign o_data_rd_en  = w_fire;

    // Any response code ends the burst
    assign o_axi_bready  = (state == ST_RESP);
    assign o_done        = b_fire;

endmodule

`default_nettype wire

//--- src/s2mm_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "s2mm_cfg.svh"

module s2mm_top
    import s2mm_pkg::*;
(
    input  wire                     M_AXI_ACLK,
    input  wire                     M_AXI_ARESETN,
    input  wire                     i_axis_valid,
    input  wire [`S2MM_DATA_W-1:0]  i_axis_data,
    input  wire                     i_axis_last,
    output beat_cnt_t               o_mem_req_len,
    output logic                    o_mem_req_valid,
    input  wire                     i_mem_req_ready,
    input  wire [`S2MM_ADDR_W-1:0]  i_mem_ack_addr,
    input  wire                     i_mem_ack_valid,
    output logic                    o_mem_ack_ready,
    output aw_req_t                 o_axi_aw,
    output logic                    o_axi_awvalid,
    input  wire                     i_axi_awready,
    output w_beat_t                 o_axi_w,
    output logic                    o_axi_wvalid,
    input  wire                     i_axi_wready,
    input  axi_resp_t               i_axi_bresp,
    input  wire                     i_axi_bvalid,
    output logic                    o_axi_bready
);

    logic                    data_wr_en;
    stream_beat_t            data_wr;
    logic                    data_rd_en;
    stream_beat_t            data_head;
    logic                    len_wr_en;
    beat_cnt_t               len_wr;
    logic                    len_rd_en;
    beat_cnt_t               len_head;
    logic                    len_empty;
    logic                    start;
    logic [`S2MM_ADDR_W-1:0] start_addr;
    beat_cnt_t               start_len;
    logic                    done;

    //////////////////////////////////////////////////
    // Stream capture and buffering
    //////////////////////////////////////////////////

    stream_ingress u_ingress (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_axis_valid  (i_axis_valid),
        .i_axis_data   (i_axis_data),
        .i_axis_last   (i_axis_last),
        .o_data_wr_en  (data_wr_en),
        .o_data_wr     (data_wr),
        .o_len_wr_en   (len_wr_en),
        .o_len_wr      (len_wr)
    );

    sync_fifo #(
        .T     (stream_beat_t),
        .DEPTH (`S2MM_DATA_DEPTH)
    ) u_data_fifo (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_wr_en       (data_wr_en),
        .i_wr_data     (data_wr),
        .i_rd_en       (data_rd_en),
        .o_rd_data     (data_head),
        .o_empty       (),
        .o_full        ()
    );

    sync_fifo #(
        .T     (beat_cnt_t),
        .DEPTH (`S2MM_LEN_DEPTH)
    ) u_len_fifo (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_wr_en       (len_wr_en),
        .i_wr_data     (len_wr),
        .i_rd_en       (len_rd_en),
        .o_rd_data     (len_head),
        .o_empty       (len_empty),
        .o_full        ()
    );

    //////////////////////////////////////////////////
    // Buffer request and AXI burst
    //////////////////////////////////////////////////

    buffer_request u_request (
        .M_AXI_ACLK      (M_AXI_ACLK),
        .M_AXI_ARESETN   (M_AXI_ARESETN),
        .i_len_empty     (len_empty),
        .i_len_head      (len_head),
        .o_len_rd_en     (len_rd_en),
        .o_mem_req_len   (o_mem_req_len),
        .o_mem_req_valid (o_mem_req_valid),
        .i_mem_req_ready (i_mem_req_ready),
        .i_mem_ack_addr  (i_mem_ack_addr),
        .i_mem_ack_valid (i_mem_ack_valid),
        .o_mem_ack_ready (o_mem_ack_ready),
        .o_start         (start),
        .o_start_addr    (start_addr),
        .o_start_len     (start_len),
        .i_done          (done)
    );

    axi_burst_writer u_writer (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_start       (start),
        .i_start_addr  (start_addr),
        .i_start_len   (start_len),
        .i_data_head   (data_head),
        .o_data_rd_en  (data_rd_en),
        .o_axi_aw      (o_axi_aw),
        .o_axi_awvalid (o_axi_awvalid),
        .i_axi_awready (i_axi_awready),
        .o_axi_w       (o_axi_w),
        .o_axi_wvalid  (o_axi_wvalid),
        .i_axi_wready  (i_axi_wready),
        .i_axi_bresp   (i_axi_bresp),
        .i_axi_bvalid  (i_axi_bvalid),
        .o_axi_bready  (o_axi_bready),
        .o_done        (done)
    );

endmodule

`default_nettype wire

//--- testbench/tb_s2mm_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "s2mm_cfg.svh"

module tb_s2mm_top
    import s2mm_pkg::*;
;

    logic                    M_AXI_ACLK;
    logic                    M_AXI_ARESETN;
    logic                    i_axis_valid;
    logic [`S2MM_DATA_W-1:0] i_axis_data;
    logic                    i_axis_last;
    beat_cnt_t               o_mem_req_len;
    logic                    o_mem_req_valid;
    logic                    i_mem_req_ready;
    logic [`S2MM_ADDR_W-1:0] i_mem_ack_addr;
    logic                    i_mem_ack_valid;
    logic                    o_mem_ack_ready;
    aw_req_t                 o_axi_aw;
    logic                    o_axi_awvalid;
    logic                    i_axi_awready;
    w_beat_t                 o_axi_w;
    logic                    o_axi_wvalid;
    logic                    i_axi_wready;
    axi_resp_t               i_axi_bresp;
    logic                    i_axi_bvalid;
    logic                    o_axi_bready;

    // Generated packets and the expected traffic
    int                      pkt_len[$];
    logic [`S2MM_DATA_W-1:0] gen_data[$];
    beat_cnt_t               exp_len_q[$];
    w_beat_t                 exp_w_q[$];
    logic [`S2MM_ADDR_W-1:0] ack_addr_q[$];

    int   total_beats = 0;
    int   sent_beats = 0;
    int   req_idx = 0;
    int   aw_idx = 0;
    int   w_idx = 0;
    int   b_cnt = 0;
    logic gen_done = 1'b0;
    logic stall_on = 1'b0;
    logic burst_open = 1'b0;

    // Handshakes seen at the falling edge complete at the next rising edge
    logic s_req_valid = 1'b0;
    logic s_req_hs = 1'b0;
    logic s_ack_hs = 1'b0;
    logic s_w_hs = 1'b0;
    logic s_w_last = 1'b0;
    logic s_b_hs = 1'b0;

    s2mm_top dut_i (.*);

    initial begin
        M_AXI_ACLK = 1'b0;
        forever #2 M_AXI_ACLK = ~M_AXI_ACLK;
    end

    task automatic check_eq(input logic [127:0] got, input logic [127:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    function automatic int rand_delay();
        return stall_on ? int'($urandom % 7) : int'($urandom % 2);
    endfunction

    // Expected lengths and W beats from the packet list
    function automatic void build_expected();
        w_beat_t w;
        int      off;
        off = 0;
        foreach (pkt_len[p]) begin
            exp_len_q.push_back(beat_cnt_t'(pkt_len[p]));
            for (int b = 0; b < pkt_len[p]; b++) begin
                w.data = gen_data[off + b];
                w.strb = '1;
                w.last = (b == pkt_len[p] - 1);
                exp_w_q.push_back(w);
            end
            off += pkt_len[p];
        end
    endfunction

    //////////////////////////////////////////////////
    // Stream source
    //////////////////////////////////////////////////

    task automatic send_packet(input int p);
        int n;
        n = pkt_len[p];
        // Keep both FIFOs well below full
        while ((sent_beats - w_idx + n) > 448 || (p - req_idx) > 48) begin
            @(posedge M_AXI_ACLK);
            i_axis_valid <= 1'b0;
        end
        for (int b = 0; b < n; b++) begin
            if (stall_on && ($urandom % 4 == 0)) begin
                @(posedge M_AXI_ACLK);
                i_axis_valid <= 1'b0;
            end
            @(posedge M_AXI_ACLK);
            i_axis_valid <= 1'b1;
            i_axis_data  <= gen_data[sent_beats];
            i_axis_last  <= (b == n - 1);
            sent_beats++;
        end
    endtask

    task automatic wait_bursts(input int n);
        @(posedge M_AXI_ACLK);
        i_axis_valid <= 1'b0;
        while (b_cnt < n) begin
            @(posedge M_AXI_ACLK);
        end
    endtask

    //////////////////////////////////////////////////
    // Buffer manager and memory models
    //////////////////////////////////////////////////

    initial begin : buffer_manager
        logic [`S2MM_ADDR_W-1:0] next_addr;
        next_addr = 32'h8000_0000;
        forever begin
            do @(posedge M_AXI_ACLK); while (!s_req_valid);
            repeat (rand_delay()) @(posedge M_AXI_ACLK);
            i_mem_req_ready <= 1'b1;
            do @(posedge M_AXI_ACLK); while (!s_req_hs);
            i_mem_req_ready <= 1'b0;
            repeat (rand_delay()) @(posedge M_AXI_ACLK);
            i_mem_ack_valid <= 1'b1;
            i_mem_ack_addr  <= next_addr;
            do @(posedge M_AXI_ACLK); while (!s_ack_hs);
            i_mem_ack_valid <= 1'b0;
            // 4 KiB aligned buffers
            next_addr = next_addr + 32'h1000;
        end
    end

    always @(posedge M_AXI_ACLK) begin
        i_axi_awready <= stall_on ? ($urandom % 3 != 0) : 1'b1;
        i_axi_wready  <= stall_on ? ($urandom % 3 != 0) : 1'b1;
    end

    initial begin : write_response
        forever begin
            @(posedge M_AXI_ACLK);
            if (s_w_hs && s_w_last) begin
                repeat (rand_delay()) @(posedge M_AXI_ACLK);
                i_axi_bvalid <= 1'b1;
                i_axi_bresp  <= stall_on ? axi_resp_t'($urandom % 4) : 2'b00;
                do @(posedge M_AXI_ACLK); while (!s_b_hs);
                i_axi_bvalid <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Checker
    //////////////////////////////////////////////////

    always @(negedge M_AXI_ACLK) begin
        s_req_valid = M_AXI_ARESETN && o_mem_req_valid && !i_mem_req_ready;
        s_req_hs    = M_AXI_ARESETN && o_mem_req_valid && i_mem_req_ready;
        s_ack_hs    = M_AXI_ARESETN && o_mem_ack_ready && i_mem_ack_valid;
        s_w_hs      = M_AXI_ARESETN && o_axi_wvalid && i_axi_wready;
        s_w_last    = o_axi_w.last;
        s_b_hs      = M_AXI_ARESETN && o_axi_bready && i_axi_bvalid;
        if (s_req_hs) begin
            check_eq(req_idx < exp_len_q.size(), 1, "request count");
            check_eq(burst_open, 1'b0, "request during open burst");
            check_eq(o_mem_req_len, exp_len_q[req_idx], "request length");
            req_idx++;
        end
        // Ack ready only between a request and its ack
        if (M_AXI_ARESETN && o_mem_ack_ready) begin
            check_eq(req_idx, ack_addr_q.size() + 1, "ack ready without a pending request");
        end
        if (s_ack_hs) begin
            ack_addr_q.push_back(i_mem_ack_addr);
            burst_open = 1'b1;
        end
        if (M_AXI_ARESETN && o_axi_awvalid && i_axi_awready) begin
            check_eq(aw_idx < ack_addr_q.size(), 1, "AW before its ack");
            check_eq(o_axi_aw.addr, ack_addr_q[aw_idx], "AWADDR");
            check_eq(o_axi_aw.len, exp_len_q[aw_idx] - 1, "AWLEN");
            check_eq(o_axi_aw.size, 3'd3, "AWSIZE");
            check_eq(o_axi_aw.burst, 2'b01, "AWBURST");
            check_eq(o_axi_aw.cache, 4'b0010, "AWCACHE");
            aw_idx++;
        end
        if (s_w_hs) begin
            check_eq(w_idx < exp_w_q.size(), 1, "W beat count");
            check_eq(o_axi_w, exp_w_q[w_idx], "W beat");
            w_idx++;
        end
        if (s_b_hs) begin
            burst_open = 1'b0;
            b_cnt++;
        end
    end

    initial begin : watchdog
        wait (gen_done);
        repeat (total_beats * 40 + 2000) @(posedge M_AXI_ACLK);
        $display("Test failures found");
        $fatal(1, "Watchdog timeout, the bursts did not all complete");
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin : main
        int rnd_init;
        M_AXI_ARESETN   = 1'b0;
        i_axis_valid    = 1'b0;
        i_axis_data     = '0;
        i_axis_last     = 1'b0;
        i_mem_req_ready = 1'b0;
        i_mem_ack_addr  = '0;
        i_mem_ack_valid = 1'b0;
        i_axi_awready   = 1'b0;
        i_axi_wready    = 1'b0;
        i_axi_bresp     = 2'b00;
        i_axi_bvalid    = 1'b0;
        rnd_init = $urandom(32'h72a2);

        // Directed lengths, then back to back, then stalled traffic
        pkt_len.push_back(5);
        pkt_len.push_back(1);
        pkt_len.push_back(`S2MM_MAX_BEATS);
        repeat (10) pkt_len.push_back(1 + $urandom % 40);
        repeat (20) pkt_len.push_back(1 + $urandom % 64);
        foreach (pkt_len[p]) begin
            total_beats += pkt_len[p];
        end
        repeat (total_beats) gen_data.push_back({$urandom, $urandom});
        build_expected();
        gen_done = 1'b1;

        repeat (5) @(posedge M_AXI_ACLK);
        M_AXI_ARESETN <= 1'b1;

        // Idle outputs after reset
        repeat (10) begin
            @(negedge M_AXI_ACLK);
            check_eq(o_mem_req_valid, 1'b0, "mem_req_valid after reset");
            check_eq(o_mem_ack_ready, 1'b0, "mem_ack_ready after reset");
            check_eq(o_axi_awvalid, 1'b0, "awvalid after reset");
            check_eq(o_axi_wvalid, 1'b0, "wvalid after reset");
            check_eq(o_axi_bready, 1'b0, "bready after reset");
        end

        send_packet(0);
        wait_bursts(1);
        send_packet(1);
        send_packet(2);
        wait_bursts(3);
        for (int p = 3; p < 13; p++) begin
            send_packet(p);
        end
        wait_bursts(13);
        stall_on = 1'b1;
        for (int p = 13; p < pkt_len.size(); p++) begin
            send_packet(p);
        end
        wait_bursts(pkt_len.size());

        repeat (5) @(posedge M_AXI_ACLK);
        check_eq(req_idx, pkt_len.size(), "total requests");
        check_eq(aw_idx, pkt_len.size(), "total AW phases");
        check_eq(w_idx, total_beats, "total W beats");
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
common/s2mm_pkg.sv
src/sync_fifo.sv
src/stream_ingress.sv
src/buffer_request.sv
axi_burst_writer/axi_burst_writer.sv
src/s2mm_top.sv
testbench/tb_s2mm_top.sv
